//--- bridge_pkg.sv
// AHB to APB bridge package
// Bus widths, AHB transfer codes, slave count, the fixed APB address map
// and the APB sequencer state encoding

package bridge_pkg;

  // ------------------------------
  // Bus words and slave vectors
  // ------------------------------
  localparam int BUS_WIDTH  = 32;
  localparam int NUM_SLAVES = 4;

  typedef logic [BUS_WIDTH-1:0] bus_word_t;

  // One bit per slave, used for psel and pready
  typedef logic [NUM_SLAVES-1:0] slave_vec_t;

  // Read data of every slave side by side, slave 0 in the low word
  typedef logic [NUM_SLAVES-1:0][BUS_WIDTH-1:0] slave_data_t;

  // ------------------------------
  // AHB transfer codes
  // ------------------------------
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // ------------------------------
  // Address map, inclusive ranges
  // ------------------------------
  localparam bus_word_t SLAVE_BASE [NUM_SLAVES] = '{
    32'h0000_0000,
    32'h0000_1000,
    32'h0001_0000,
    32'h0002_0000
  };

  localparam bus_word_t SLAVE_LAST [NUM_SLAVES] = '{
    32'h0000_0FFF,
    32'h0000_1FFF,
    32'h0001_00FF,
    32'h0002_FFFF
  };

  // APB sequencer state, one-hot
  typedef enum logic [2:0] {
    APB_IDLE   = 3'b001,
    APB_SETUP  = 3'b010,
    APB_ACCESS = 3'b100
  } apb_state_t;

endpackage

//--- xfer_if.sv
// Transfer handoff between the AHB port and the APB sequencer
// Carries one captured AHB transfer forward and its completion back

`timescale 1ns/1ps

interface xfer_if
  import bridge_pkg::*;
();

  // Request side, held stable while req is high
  logic       req;
  bus_word_t  addr;
  logic       write;
  slave_vec_t sel;

  // Completion, single cycle pulse with read data alongside
  logic       done;
  bus_word_t  rdata;

  modport port_side (
    output req, addr, write, sel,
    input  done, rdata
  );

  modport fsm_side (
    input  req, addr, write, sel,
    output done, rdata
  );

endinterface

//--- ahb_slave_port.sv
// AHB slave port of the AHB to APB bridge
// Tracks address and data phase, decodes haddr against the slave map,
// captures the accepted transfer and hands it to the APB sequencer.
// Drives hready low for the data phase and returns read data on hrdata

`timescale 1ns/1ps

module ahb_slave_port
  import bridge_pkg::*;
(
  input  logic       hclk24,
  input  logic       hreset_n24,

  input  logic       hsel,
  input  bus_word_t  haddr,
  input  logic [1:0] htrans,
  input  logic       hwrite,
  output logic       hready,
  output bus_word_t  hrdata,

  xfer_if.port_side  xfer
);

  slave_vec_t sel_dec;
  logic       addr_hit;
  logic       trans_valid;
  logic       accept;

  // Data phase flag doubles as the request level
  logic       data_phase;
  bus_word_t  addr_q;
  logic       write_q;
  slave_vec_t sel_q;

  // ------------------------------
  // Address decode
  // ------------------------------

  // Offset from base compared against range size, one unsigned compare
  // per slave covers both ends of the inclusive range
  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      sel_dec[i] = (haddr - SLAVE_BASE[i]) <= (SLAVE_LAST[i] - SLAVE_BASE[i]);
    end
  end

  assign addr_hit    = |sel_dec;
  assign trans_valid = hsel && ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  // Unmapped addresses are simply not taken
  assign accept = hready && trans_valid && addr_hit;

  // ------------------------------
  // Phase tracking and capture
  // ------------------------------
  always_ff @(posedge hclk24 or negedge hreset_n24) begin
    if (!hreset_n24) begin
      data_phase <= 1'b0;
      hrdata     <= '0;
    end else if (data_phase) begin
      if (xfer.done) begin
        data_phase <= 1'b0;
        // Only reads update hrdata
        if (!write_q) begin
          hrdata <= xfer.rdata;
        end
      end
    end else if (accept) begin
      data_phase <= 1'b1;
    end
  end

  // Transfer payload, held until done
  always_ff @(posedge hclk24) begin
    if (accept) begin
      addr_q  <= haddr;
      write_q <= hwrite;
      sel_q   <= sel_dec;
    end
  end

  // Address phase open whenever no transfer is in flight
  assign hready = ~data_phase;

  assign xfer.req   = data_phase;
  assign xfer.addr  = addr_q;
  assign xfer.write = write_q;
  assign xfer.sel   = sel_q;

endmodule

//--- apb_master_fsm.sv
// APB master sequencer of the AHB to APB bridge
// Runs each captured transfer as setup then access cycles, holds
// everything while the selected slave stalls, and returns completion
// with the selected slave's read data

`timescale 1ns/1ps

module apb_master_fsm
  import bridge_pkg::*;
(
  input  logic        hclk24,
  input  logic        hreset_n24,

  xfer_if.fsm_side    xfer,

  output bus_word_t   paddr,
  output logic        pwrite,
  output logic        penable,
  output slave_vec_t  psel,
  input  slave_vec_t  pready,
  input  slave_data_t prdata
);

  apb_state_t state;
  logic       sel_ready;
  bus_word_t  rdata_sel;

  // ------------------------------
  // Slave response selection
  // ------------------------------

  // Ready of the selected slave only
  assign sel_ready = |(psel & pready);

  // AND-OR mux, psel is one-hot or zero
  always_comb begin
    rdata_sel = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      rdata_sel = rdata_sel | (prdata[i] & {BUS_WIDTH{psel[i]}});
    end
  end

  // Completion in the access cycle that the slave accepts
  assign xfer.done  = (state == APB_ACCESS) && sel_ready;
  assign xfer.rdata = rdata_sel;

  // ------------------------------
  // Sequencer
  // ------------------------------
  always_ff @(posedge hclk24 or negedge hreset_n24) begin
    if (!hreset_n24) begin
      state   <= APB_IDLE;
      paddr   <= '0;
      pwrite  <= 1'b0;
      penable <= 1'b0;
      psel    <= '0;
    end else begin
      unique case (state)
        APB_IDLE: begin
          // Load the captured transfer on entry to setup
          if (xfer.req) begin
            state  <= APB_SETUP;
            paddr  <= xfer.addr;
            pwrite <= xfer.write;
            psel   <= xfer.sel;
          end
        end

        APB_SETUP: begin
          state   <= APB_ACCESS;
          penable <= 1'b1;
        end

        APB_ACCESS: begin
          // Wait states hold all outputs as they are
          if (sel_ready) begin
            state   <= APB_IDLE;
            penable <= 1'b0;
            psel    <= '0;
          end
        end

        default: begin
          state   <= APB_IDLE;
          penable <= 1'b0;
          psel    <= '0;
        end
      endcase
    end
  end

endmodule

//--- ahb2apb_bridge.sv
// AHB to APB bridge, top level
// Single AHB transfers are run one at a time as APB setup and access
// cycles on one of four slaves. AHB and APB share hclk24

`timescale 1ns/1ps

module ahb2apb_bridge
  import bridge_pkg::*;
(
  input  logic        hclk24,
  input  logic        hreset_n24,

  // ------------------------------
  // AHB slave side
  // ------------------------------
  input  logic        hsel,
  input  bus_word_t   haddr,
  input  logic [1:0]  htrans,
  input  bus_word_t   hwdata,
  input  logic        hwrite,
  output bus_word_t   hrdata,
  output logic        hready,

  // ------------------------------
  // APB master side
  // ------------------------------
  output bus_word_t   paddr,
  output logic        penable,
  output logic        pwrite,
  output bus_word_t   pwdata,
  output slave_vec_t  psel,
  input  slave_vec_t  pready,
  input  slave_data_t prdata
);

  xfer_if xfer ();

  ahb_slave_port u_ahb_slave_port (
    .hclk24     (hclk24),
    .hreset_n24 (hreset_n24),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hready     (hready),
    .hrdata     (hrdata),
    .xfer       (xfer.port_side)
  );

  apb_master_fsm u_apb_master_fsm (
    .hclk24     (hclk24),
    .hreset_n24 (hreset_n24),
    .xfer       (xfer.fsm_side),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .penable    (penable),
    .psel       (psel),
    .pready     (pready),
    .prdata     (prdata)
  );

  // Master keeps hwdata stable through the stalled data phase
  assign pwdata = hwdata;

endmodule

//--- tb_checker.sv
// Checker for the AHB to APB bridge testbench
// Watches the DUT ports cycle by cycle, follows each accepted transfer
// through setup and access, and compares against the expected values
// that the stimulus supplies with every transfer

`timescale 1ns/1ps

module tb_checker
  import bridge_pkg::*;
(
  input  logic       hclk24,
  input  logic       hreset_n24,
  input  bus_word_t  haddr,
  input  logic       hwrite,
  input  logic       hready,
  input  bus_word_t  hrdata,
  input  bus_word_t  paddr,
  input  logic       penable,
  input  logic       pwrite,
  input  bus_word_t  pwdata,
  input  slave_vec_t psel,
  input  slave_vec_t exp_sel,
  input  bus_word_t  exp_rdata,
  input  bus_word_t  exp_wdata,
  input  logic [1:0] exp_waits,
  output int         err_count,
  output int         check_count,
  output int         xfer_count
);

  logic       tracking;
  int         low_cycles;
  int         reset_cycles;
  bus_word_t  cap_addr;
  bus_word_t  cap_rdata;
  bus_word_t  cap_wdata;
  logic       cap_write;
  slave_vec_t cap_sel;
  int         cap_waits;

  task automatic check_word(input string what, input bus_word_t got, input bus_word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ------------------------------
  // Per-cycle comparison
  // ------------------------------
  always @(posedge hclk24) begin
    if (!hreset_n24) begin
      tracking = 1'b0;
      low_cycles = 0;
      // First edge may come before the flops have seen reset
      if (reset_cycles > 0) begin
        check_word("hready in reset", bus_word_t'(hready), 32'd1);
        check_word("psel in reset", bus_word_t'(psel), 32'd0);
        check_word("penable in reset", bus_word_t'(penable), 32'd0);
        check_word("pwrite in reset", bus_word_t'(pwrite), 32'd0);
        check_word("paddr in reset", paddr, 32'd0);
        check_word("hrdata in reset", hrdata, 32'd0);
      end
      reset_cycles++;
    end else if (tracking && !hready) begin
      low_cycles++;
      if (low_cycles == 1) begin
        // Capture cycle, APB still quiet
        check_word("psel after capture", bus_word_t'(psel), 32'd0);
        check_word("penable after capture", bus_word_t'(penable), 32'd0);
      end else begin
        check_word("psel", bus_word_t'(psel), bus_word_t'(cap_sel));
        check_word("paddr", paddr, cap_addr);
        check_word("pwrite", bus_word_t'(pwrite), bus_word_t'(cap_write));
        check_word("penable", bus_word_t'(penable), bus_word_t'(low_cycles > 2));
        if (cap_write) begin
          check_word("pwdata", pwdata, cap_wdata);
        end
      end
    end else begin
      if (tracking) begin
        check_word("hready low cycles", bus_word_t'(low_cycles), bus_word_t'(3 + cap_waits));
        if (!cap_write) begin
          check_word("hrdata", hrdata, cap_rdata);
        end
        xfer_count++;
        tracking = 1'b0;
      end else if (!hready) begin
        err_count++;
        $display("hready went low at %0t ns with no accepted transfer", $time);
      end
      check_word("psel while idle", bus_word_t'(psel), 32'd0);
      check_word("penable while idle", bus_word_t'(penable), 32'd0);
      // New transfer accepted on this edge
      if (hready && exp_sel != '0) begin
        tracking = 1'b1;
        low_cycles = 0;
        cap_addr = haddr;
        cap_write = hwrite;
        cap_sel = exp_sel;
        cap_rdata = exp_rdata;
        cap_wdata = exp_wdata;
        cap_waits = int'(exp_waits);
      end
    end
  end

endmodule

//--- tb_top.sv
// Testbench for the AHB to APB bridge
// Random single AHB transfers from an LFSR, four APB slave models with
// wait states, and a reference model of the address map and read data

`timescale 1ns/1ps

module tb_top
  import bridge_pkg::*;
();

  localparam int NUM_XFERS   = 300;
  localparam int CYCLE_LIMIT = NUM_XFERS * 8 + 64;
  localparam bus_word_t GAP_BASE [4] = '{
    32'h0000_2000, 32'h0001_0100, 32'h0003_0000, 32'hFFFF_FF00
  };

  logic        hclk24 = 1'b0;
  logic        hreset_n24;
  logic        hsel;
  bus_word_t   haddr;
  logic [1:0]  htrans;
  bus_word_t   hwdata;
  logic        hwrite;
  bus_word_t   hrdata;
  logic        hready;
  bus_word_t   paddr;
  logic        penable;
  logic        pwrite;
  bus_word_t   pwdata;
  slave_vec_t  psel;
  wire slave_vec_t  pready;
  wire slave_data_t prdata;

  logic [1:0]  wait_states;
  slave_vec_t  exp_sel;
  bus_word_t   exp_rdata;
  bus_word_t   exp_wdata;
  bus_word_t   lfsr;
  bus_word_t   shadow [bus_word_t];
  int          cycles;
  int          err_count;
  int          check_count;
  int          xfer_count;

  always #20 hclk24 = ~hclk24;

  // ------------------------------
  // Random source and reference
  // ------------------------------
  // Taps 32, 22, 2, 1
  function automatic bus_word_t lfsr_step(input bus_word_t s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output bus_word_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Expected slave for an address, -1 when unmapped
  function automatic int ref_slave(input bus_word_t addr);
    int idx;
    idx = -1;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      if (addr >= SLAVE_BASE[s] && addr <= SLAVE_LAST[s]) begin
        idx = s;
      end
    end
    return idx;
  endfunction

  function automatic bus_word_t ref_read(input bus_word_t addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return addr ^ 32'hA5A5_0000;
  endfunction

  // Low 32 words of a range map to 0..31, top 32 words to 32..63
  function automatic int word_index(input int s, input bus_word_t addr);
    bus_word_t off;
    off = addr - SLAVE_BASE[s];
    if (off < 32'd128) begin
      return int'(off[6:2]);
    end
    return 32 + int'((SLAVE_LAST[s] - addr) >> 2);
  endfunction

  // ------------------------------
  // APB slave models
  // ------------------------------
  for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
    bus_word_t   mem [64];
    logic [63:0] written = '0;
    logic        rdy = 1'b0;
    bus_word_t   rd = '0;
    int          acc_cnt = 0;

    always @(negedge hclk24) begin
      int idx;
      idx = word_index(s, paddr);
      if (psel[s]) begin
        rd = written[idx] ? mem[idx] : (paddr ^ 32'hA5A5_0000);
      end
      if (psel[s] && penable) begin
        if (acc_cnt == int'(wait_states)) begin
          rdy = 1'b1;
          if (pwrite) begin
            mem[idx] = pwdata;
            written[idx] = 1'b1;
          end
        end else begin
          rdy = 1'b0;
          acc_cnt++;
        end
      end else begin
        rdy = 1'b0;
        acc_cnt = 0;
      end
    end

    assign pready[s] = rdy;
    assign prdata[s] = rd;
  end

  ahb2apb_bridge UUT (
    .hclk24     (hclk24),
    .hreset_n24 (hreset_n24),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwdata     (hwdata),
    .hwrite     (hwrite),
    .hrdata     (hrdata),
    .hready     (hready),
    .paddr      (paddr),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .psel       (psel),
    .pready     (pready),
    .prdata     (prdata)
  );

  tb_checker u_checker (
    .hclk24      (hclk24),
    .hreset_n24  (hreset_n24),
    .haddr       (haddr),
    .hwrite      (hwrite),
    .hready      (hready),
    .hrdata      (hrdata),
    .paddr       (paddr),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .psel        (psel),
    .exp_sel     (exp_sel),
    .exp_rdata   (exp_rdata),
    .exp_wdata   (exp_wdata),
    .exp_waits   (wait_states),
    .err_count   (err_count),
    .check_count (check_count),
    .xfer_count  (xfer_count)
  );

  always @(posedge hclk24) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    bus_word_t kind, slv, offs, dir, data, wt, pick, woff, addr;
    int idx;
    hreset_n24 = 1'b0;
    hsel = 1'b0;
    haddr = '0;
    htrans = 2'b00;
    hwdata = '0;
    hwrite = 1'b0;
    wait_states = 2'd0;
    exp_sel = '0;
    exp_rdata = '0;
    exp_wdata = '0;
    lfsr = 32'h76fa_df48;
    repeat (3) @(negedge hclk24);
    hreset_n24 = 1'b1;

    for (int n = 0; n < NUM_XFERS; n++) begin
      take_bits(3, kind);
      take_bits(2, slv);
      take_bits(6, offs);
      take_bits(1, dir);
      take_bits(32, data);
      take_bits(2, wt);
      take_bits(2, pick);
      woff = {25'd0, offs[4:0], 2'b00};
      if (kind == 2) begin
        addr = GAP_BASE[int'(pick)] + woff;
      end else if (offs[5]) begin
        addr = SLAVE_LAST[int'(slv)] - 32'd3 - woff;
      end else begin
        addr = SLAVE_BASE[int'(slv)] + woff;
      end
      // kind 0 idle or busy, 1 not selected, 2 unmapped, else a real transfer
      hsel = (kind != 1);
      haddr = addr;
      hwrite = dir[0];
      htrans = (kind == 0) ? {1'b0, data[0]} : (data[1] ? HTRANS_SEQ : HTRANS_NONSEQ);
      wait_states = wt[1:0];
      idx = ref_slave(addr);
      exp_sel = '0;
      if (hsel && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ) && idx >= 0) begin
        exp_sel[idx] = 1'b1;
      end
      exp_rdata = ref_read(addr);
      exp_wdata = data;
      @(negedge hclk24);
      if (exp_sel != '0 && hwrite) begin
        shadow[addr] = data;
      end
      hsel = 1'b0;
      htrans = 2'b00;
      hwdata = data;
      exp_sel = '0;
      while (!hready) @(negedge hclk24);
    end

    repeat (2) @(negedge hclk24);
    $display("Errors %0d, checks %0d, completed transfers %0d",
             err_count, check_count, xfer_count);
    if (err_count == 0 && xfer_count != 0) begin
      $display("Verification passed");
    end else begin
      if (xfer_count == 0) begin
        $display("No transfer completed during the run");
      end
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
bridge_pkg.sv
xfer_if.sv
ahb_slave_port.sv
apb_master_fsm.sv
ahb2apb_bridge.sv
tb_checker.sv
tb_top.sv

//--- Makefile
TOP_TB  = tb_top
TOP_RTL = ahb2apb_bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module $(TOP_RTL) bridge_pkg.sv xfer_if.sv \
		ahb_slave_port.sv apb_master_fsm.sv ahb2apb_bridge.sv

sim:
	verilator --binary --timing --top-module $(TOP_TB) -f filelist.f -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
